// File: rtl/lsu_pkg.sv
package lsu_pkg;

  // ------------------------------------------------------------------
  // widths and sizes
  // ------------------------------------------------------------------
  localparam int unsigned XLEN        = 32;
  localparam int unsigned BE_W        = XLEN / 8;
  localparam int unsigned TRANS_ID_W  = 3;
  localparam int unsigned MEM_WORDS   = 16;
  localparam int unsigned MEM_IDX_W   = 4;
  localparam int unsigned QUEUE_DEPTH = 4;
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);

  // ------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------
  typedef enum logic [2:0] {
    LB, LBU, LH, LHU, LW, SB, SH, SW
  } lsu_op_e;

  // values match the RISC-V mcause codes
  typedef enum logic [3:0] {
    LD_ADDR_MISALIGNED = 4'd4,
    ST_ADDR_MISALIGNED = 4'd6
  } exc_cause_e;

  typedef enum logic {
    IDLE,
    LOAD_WAIT
  } mem_op_st_e;

  // ------------------------------------------------------------------
  // records
  // ------------------------------------------------------------------
  typedef struct packed {
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [XLEN-1:0]       imm;
    lsu_op_e               op;
    logic [TRANS_ID_W-1:0] trans_id;
  } lsu_fu_data_t;

  typedef struct packed {
    logic            valid;
    exc_cause_e      cause;
    logic [XLEN-1:0] tval;
  } exception_t;

  // one request queue entry
  typedef struct packed {
    logic [XLEN-1:0]       addr;
    logic [XLEN-1:0]       data;
    logic [BE_W-1:0]       be;
    lsu_op_e               op;
    logic [TRANS_ID_W-1:0] trans_id;
    logic                  misaligned;
  } lsu_ctrl_t;

  typedef struct packed {
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]       result;
    exception_t            ex;
  } lsu_wb_t;

endpackage

// File: rtl/lsu_agu.sv
`timescale 1ns/1ps

module lsu_agu (
  input  lsu_pkg::lsu_fu_data_t fu_data_i,
  output lsu_pkg::lsu_ctrl_t    req_o
);
  import lsu_pkg::*;

  logic [XLEN-1:0] addr;
  logic [BE_W-1:0] be;
  logic            is_half;
  logic            is_word;
  logic            misaligned;

  // ------------------------------------------------------------------
  // address generation
  // ------------------------------------------------------------------
  // imm is sign extended by decode, so a signed add gives base + offset
  assign addr = $unsigned($signed(fu_data_i.operand_a) + $signed(fu_data_i.imm));

  // transfer size from opcode, bytes otherwise
  assign is_half = fu_data_i.op inside {LH, LHU, SH};
  assign is_word = fu_data_i.op inside {LW, SW};

  // ------------------------------------------------------------------
  // byte enables
  // ------------------------------------------------------------------
  always_comb begin
    if (is_word) begin
      be = '1;
    end else if (is_half) begin
      be = BE_W'(2'b11) << addr[1:0];
    end else begin
      be = BE_W'(1'b1) << addr[1:0];
    end
  end

  // ------------------------------------------------------------------
  // misalignment check
  // ------------------------------------------------------------------
  // bytes can never be misaligned
  always_comb begin
    misaligned = 1'b0;
    if (is_half && addr[0]) begin
      misaligned = 1'b1;
    end
    if (is_word && (addr[1:0] != 2'b00)) begin
      misaligned = 1'b1;
    end
  end

  // queue entry
  assign req_o.addr       = addr;
  // store data moved into its byte lanes
  assign req_o.data       = fu_data_i.operand_b << {addr[1:0], 3'b000};
  assign req_o.be         = be;
  assign req_o.op         = fu_data_i.op;
  assign req_o.trans_id   = fu_data_i.trans_id;
  assign req_o.misaligned = misaligned;

endmodule

// File: rtl/lsu_req_queue.sv
`timescale 1ns/1ps

module lsu_req_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  lsu_pkg::lsu_ctrl_t req_i,
  output logic               ready_o,
  input  logic               pop_i,
  output lsu_pkg::lsu_ctrl_t head_o,
  output logic               not_empty_o
);
  import lsu_pkg::*;

  lsu_ctrl_t              entries_q [QUEUE_DEPTH];
  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [QUEUE_PTR_W:0]   count_q;

  assign ready_o     = (count_q != (QUEUE_PTR_W + 1)'(QUEUE_DEPTH));
  assign not_empty_o = (count_q != '0);
  assign head_o      = entries_q[rd_ptr_q];

  // entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entries_q[wr_ptr_q] <= req_i;
    end
  end

  // pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // assertions
  // ------------------------------------------------------------------
  // push comes from the top, gated by the input handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> ready_o)
    else $error("request queue: push while full");

  // pop comes from the memory unit
  assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> not_empty_o)
    else $error("request queue: pop while empty");

endmodule

// File: rtl/lsu_mem_unit.sv
`timescale 1ns/1ps

module lsu_mem_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  lsu_pkg::lsu_ctrl_t head_i,
  input  logic               not_empty_i,
  output logic               pop_o,
  output logic               load_valid_o,
  output logic               store_valid_o,
  output lsu_pkg::lsu_wb_t   load_wb_o,
  output lsu_pkg::lsu_wb_t   store_wb_o
);
  import lsu_pkg::*;

  logic [XLEN-1:0]      mem_q [MEM_WORDS];
  logic [MEM_IDX_W-1:0] head_idx;
  logic                 head_is_load;
  mem_op_st_e           state_q;
  mem_op_st_e           state_d;

  // load in flight
  lsu_ctrl_t            ld_req_q;
  logic [XLEN-1:0]      rd_word_q;
  logic [XLEN-1:0]      rd_shifted;

  logic                 store_valid_q;
  lsu_wb_t              store_wb_q;

  // upper address bits ignored so the memory wraps every 64 bytes
  assign head_idx     = head_i.addr[MEM_IDX_W+1:2];
  assign head_is_load = head_i.op inside {LB, LBU, LH, LHU, LW};

  // ------------------------------------------------------------------
  // control FSM
  // ------------------------------------------------------------------
  // no pop while a load waits for its writeback
  assign pop_o = (state_q == IDLE) && not_empty_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:      if (pop_o && head_is_load) state_d = LOAD_WAIT;
      LOAD_WAIT: state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      store_valid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      store_valid_q <= pop_o && !head_is_load;
    end
  end

  // ------------------------------------------------------------------
  // data memory
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < MEM_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (pop_o && !head_is_load && !head_i.misaligned) begin
      for (int b = 0; b < BE_W; b++) begin
        if (head_i.be[b]) begin
          mem_q[head_idx][b*8 +: 8] <= head_i.data[b*8 +: 8];
        end
      end
    end
  end

  // read word and request captured when a load pops
  always_ff @(posedge clk_i) begin
    if (pop_o && head_is_load) begin
      rd_word_q <= mem_q[head_idx];
      ld_req_q  <= head_i;
    end
  end

  // store writeback with a zero result
  always_ff @(posedge clk_i) begin
    if (pop_o && !head_is_load) begin
      store_wb_q          <= '0;
      store_wb_q.trans_id <= head_i.trans_id;
      if (head_i.misaligned) begin
        store_wb_q.ex <= '{valid: 1'b1, cause: ST_ADDR_MISALIGNED, tval: head_i.addr};
      end
    end
  end

  assign store_valid_o = store_valid_q;
  assign store_wb_o    = store_wb_q;

  // ------------------------------------------------------------------
  // load writeback
  // ------------------------------------------------------------------
  assign rd_shifted   = rd_word_q >> {ld_req_q.addr[1:0], 3'b000};
  assign load_valid_o = (state_q == LOAD_WAIT);

  always_comb begin
    load_wb_o          = '0;
    load_wb_o.trans_id = ld_req_q.trans_id;
    if (ld_req_q.misaligned) begin
      // faulting loads return zero
      load_wb_o.ex = '{valid: 1'b1, cause: LD_ADDR_MISALIGNED, tval: ld_req_q.addr};
    end else begin
      case (ld_req_q.op)
        LB:      load_wb_o.result = {{(XLEN-8){rd_shifted[7]}}, rd_shifted[7:0]};
        LBU:     load_wb_o.result = {{(XLEN-8){1'b0}}, rd_shifted[7:0]};
        LH:      load_wb_o.result = {{(XLEN-16){rd_shifted[15]}}, rd_shifted[15:0]};
        LHU:     load_wb_o.result = {{(XLEN-16){1'b0}}, rd_shifted[15:0]};
        LW:      load_wb_o.result = rd_shifted;
        default: load_wb_o.result = '0;
      endcase
    end
  end

  // ------------------------------------------------------------------
  // assertions
  // ------------------------------------------------------------------
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(load_valid_o && store_valid_o))
    else $error("mem unit: load and store writeback in the same cycle");

  // the cycle after a load pop is its wait cycle, with writeback and no pop
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   (pop_o && head_is_load) |=> (load_valid_o && !pop_o))
    else $error("mem unit: pop during LOAD_WAIT");

endmodule

// File: rtl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  lsu_pkg::lsu_fu_data_t fu_data_i,
  input  logic                  lsu_valid_i,
  output logic                  lsu_ready_o,
  output logic                  load_valid_o,
  output logic                  store_valid_o,
  output lsu_pkg::lsu_wb_t      load_wb_o,
  output lsu_pkg::lsu_wb_t      store_wb_o
);
  import lsu_pkg::*;

  lsu_ctrl_t agu_req;
  lsu_ctrl_t queue_head;
  logic      queue_ready;
  logic      queue_not_empty;
  logic      queue_pop;
  logic      queue_push;

  // accept on valid and ready
  assign queue_push  = lsu_valid_i && queue_ready;
  assign lsu_ready_o = queue_ready;

  // ------------------------------------------------------------------
  // producer, buffer, consumer
  // ------------------------------------------------------------------
  lsu_agu lsu_agu_inst (
    .fu_data_i (fu_data_i),
    .req_o     (agu_req)
  );

  lsu_req_queue lsu_req_queue_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (queue_push),
    .req_i       (agu_req),
    .ready_o     (queue_ready),
    .pop_i       (queue_pop),
    .head_o      (queue_head),
    .not_empty_o (queue_not_empty)
  );

  lsu_mem_unit lsu_mem_unit_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .head_i        (queue_head),
    .not_empty_i   (queue_not_empty),
    .pop_o         (queue_pop),
    .load_valid_o  (load_valid_o),
    .store_valid_o (store_valid_o),
    .load_wb_o     (load_wb_o),
    .store_wb_o    (store_wb_o)
  );

endmodule

// File: dv/lsu_clk_gen.sv
`timescale 1ns/1ps

module lsu_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // reset held low for 4 cycles
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  typedef struct packed {
    lsu_op_e               op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       operand_b;
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]       exp_result;
    logic                  exp_ex_valid;
    logic [3:0]            exp_cause;
    logic [XLEN-1:0]       exp_tval;
  } stim_row_t;

  logic            clk;
  logic            rst_n;
  lsu_fu_data_t    fu_data;
  logic            lsu_valid;
  logic            lsu_ready;
  logic            load_valid;
  logic            store_valid;
  lsu_wb_t         load_wb;
  lsu_wb_t         store_wb;

  stim_row_t       stim_q[$];
  int              load_exp_q[$];
  int              store_exp_q[$];
  int              value_errors = 0;
  int              other_errors = 0;
  int              done_cnt = 0;
  int              cycle_cnt = 0;
  bit              table_ready = 1'b0;
  bit              saw_not_ready = 1'b0;
  logic [XLEN-1:0] rand_a;
  logic [XLEN-1:0] rand_b;

  lsu_clk_gen lsu_clk_gen_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lsu_top lsu_top_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .fu_data_i     (fu_data),
    .lsu_valid_i   (lsu_valid),
    .lsu_ready_o   (lsu_ready),
    .load_valid_o  (load_valid),
    .store_valid_o (store_valid),
    .load_wb_o     (load_wb),
    .store_wb_o    (store_wb)
  );

  // ------------------------------------------------------------------
  // checking helpers
  // ------------------------------------------------------------------
  task automatic check_value(input string name, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_writeback(input string name, input lsu_wb_t wb, input int idx);
    // program order across loads and stores
    if (idx != done_cnt) begin
      $display("ERROR: %s writeback for request %0d arrived out of order", name, idx);
      other_errors++;
    end
    check_value({name, ".trans_id"}, XLEN'(wb.trans_id), XLEN'(stim_q[idx].trans_id));
    check_value({name, ".result"}, wb.result, stim_q[idx].exp_result);
    check_value({name, ".ex.valid"}, XLEN'(wb.ex.valid), XLEN'(stim_q[idx].exp_ex_valid));
    check_value({name, ".ex.cause"}, XLEN'(wb.ex.cause), XLEN'(stim_q[idx].exp_cause));
    check_value({name, ".ex.tval"}, wb.ex.tval, stim_q[idx].exp_tval);
    done_cnt++;
  endtask

  task automatic add_row(input lsu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] imm,
                         input logic [XLEN-1:0] b, input logic [XLEN-1:0] result,
                         input logic ex_valid, input logic [3:0] cause,
                         input logic [XLEN-1:0] tval);
    stim_row_t row;
    row = '{op, a, imm, b, TRANS_ID_W'(stim_q.size()), result, ex_valid, cause, tval};
    if (op inside {LB, LBU, LH, LHU, LW}) begin
      load_exp_q.push_back(stim_q.size());
    end else begin
      store_exp_q.push_back(stim_q.size());
    end
    stim_q.push_back(row);
  endtask

  task automatic add_ok(input lsu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] imm,
                        input logic [XLEN-1:0] b, input logic [XLEN-1:0] result);
    add_row(op, a, imm, b, result, 1'b0, 4'h0, '0);
  endtask

  // ------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------
  task automatic build_table();
    rand_a = $urandom;
    rand_b = $urandom;
    // unwritten word 9 after reset
    add_ok(LW, 32'h0000_0020, 32'h0000_0004, 32'h0, 32'h0);
    // word 15 through negative offsets
    add_ok(SW, 32'h0000_0100, 32'hFFFF_FFFC, rand_a, 32'h0);
    add_ok(LW, 32'h0000_0104, 32'hFFFF_FFF8, 32'h0, rand_a);
    // word 1 ends up as 0xbeef7f80
    add_ok(SB, 32'h4, 32'h0, 32'h1234_5680, 32'h0);
    add_ok(SB, 32'h4, 32'h1, 32'hAAAA_AA7F, 32'h0);
    add_ok(SH, 32'h4, 32'h2, 32'h5555_BEEF, 32'h0);
    add_ok(LB, 32'h4, 32'h0, 32'h0, 32'hFFFF_FF80);
    add_ok(LBU, 32'h4, 32'h0, 32'h0, 32'h0000_0080);
    add_ok(LB, 32'h4, 32'h1, 32'h0, 32'h0000_007F);
    add_ok(LH, 32'h4, 32'h2, 32'h0, 32'hFFFF_BEEF);
    add_ok(LHU, 32'h4, 32'h2, 32'h0, 32'h0000_BEEF);
    add_ok(LH, 32'h4, 32'h0, 32'h0, 32'h0000_7F80);
    add_ok(LW, 32'h4, 32'h0, 32'h0, 32'hBEEF_7F80);
    // faulting accesses must leave word 2 untouched
    add_ok(SW, 32'h8, 32'h0, 32'h1122_3344, 32'h0);
    add_row(LH, 32'h8, 32'h1, 32'h0, 32'h0, 1'b1, LD_ADDR_MISALIGNED, 32'h9);
    add_row(SW, 32'h8, 32'h2, 32'hDEAD_BEEF, 32'h0, 1'b1, ST_ADDR_MISALIGNED, 32'hA);
    add_ok(LW, 32'h8, 32'h0, 32'h0, 32'h1122_3344);
    // 0x50 and 0x1000_0010 both hit word 4
    add_ok(SW, 32'h40, 32'h10, rand_b, 32'h0);
    add_ok(LW, 32'h1000_0000, 32'h10, 32'h0, rand_b);
    // load burst, consumer is slower than the source
    add_ok(LW, 32'h4, 32'h0, 32'h0, 32'hBEEF_7F80);
    add_ok(LW, 32'h8, 32'h0, 32'h0, 32'h1122_3344);
    add_ok(LW, 32'h10, 32'h0, 32'h0, rand_b);
    add_ok(LW, 32'hF0, 32'hC, 32'h0, rand_a);
    add_ok(LW, 32'h24, 32'h0, 32'h0, 32'h0);
    add_ok(LBU, 32'h4, 32'h3, 32'h0, 32'h0000_00BE);
    add_ok(LB, 32'h4, 32'h3, 32'h0, 32'hFFFF_FFBE);
    add_ok(LHU, 32'h8, 32'h0, 32'h0, 32'h0000_3344);
    add_ok(LB, 32'h8, 32'h3, 32'h0, 32'h0000_0011);
    add_ok(LW, 32'h0, 32'h0, 32'h0, 32'h0);
  endtask

  // ------------------------------------------------------------------
  // driver
  // ------------------------------------------------------------------
  initial begin
    bit accepted;
    void'($urandom(32'h5a77));
    fu_data   = '0;
    lsu_valid = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait (rst_n);
    @(posedge clk);
    check_value("lsu_ready_o", XLEN'(lsu_ready), 32'h1);
    check_value("load_valid_o", XLEN'(load_valid), 32'h0);
    check_value("store_valid_o", XLEN'(store_valid), 32'h0);
    foreach (stim_q[i]) begin
      fu_data <= '{operand_a: stim_q[i].operand_a, operand_b: stim_q[i].operand_b,
                   imm: stim_q[i].imm, op: stim_q[i].op, trans_id: stim_q[i].trans_id};
      lsu_valid <= 1'b1;
      // hold the row until the edge that sees ready high
      do begin
        @(negedge clk);
        accepted = lsu_ready;
        @(posedge clk);
      end while (!accepted);
    end
    lsu_valid <= 1'b0;
    while (done_cnt < stim_q.size()) begin
      @(posedge clk);
    end
    // catch stray strobes
    repeat (4) @(posedge clk);
    if (!saw_not_ready) begin
      $display("ERROR: lsu_ready_o never went low during the load burst");
      other_errors++;
    end
    $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // ------------------------------------------------------------------
  // monitor, sampled mid cycle
  // ------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (!lsu_ready) begin
        saw_not_ready = 1'b1;
      end
      if (load_valid) begin
        if (load_exp_q.size() == 0) begin
          $display("ERROR: load writeback seen with no load outstanding");
          other_errors++;
        end else begin
          check_writeback("load_wb_o", load_wb, load_exp_q.pop_front());
        end
      end
      if (store_valid) begin
        if (store_exp_q.size() == 0) begin
          $display("ERROR: store writeback seen with no store outstanding");
          other_errors++;
        end else begin
          check_writeback("store_wb_o", store_wb, store_exp_q.pop_front());
        end
      end
    end
  end

  // timeout, 4 cycles per row plus margin
  initial begin
    int limit;
    wait (table_ready);
    limit = stim_q.size() * 4 + 50;
    while (cycle_cnt < limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("ERROR: timeout after %0d cycles, only %0d of %0d requests wrote back",
             limit, done_cnt, stim_q.size());
    $display("errors: %0d value mismatches, %0d other", value_errors, other_errors + 1);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: verilog.f
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_req_queue.sv
rtl/lsu_mem_unit.sv
rtl/lsu_top.sv
dv/lsu_clk_gen.sv
dv/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Verification passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# the run fails unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
